// ==== host_link_config.svh ====
`ifndef HOST_LINK_CONFIG_SVH
`define HOST_LINK_CONFIG_SVH

// memory word and reply width
`define HL_WORD_W 16

// one serial field, command or data
`define HL_BYTE_W 8

`define HL_ADDR_W 10
`define HL_MEM_DEPTH 1024

// words summed by one checksum pass
`define HL_SCAN_WORDS 16

// flops on host_clk and host_din before use
`define HL_SYNC_STAGES 2

`endif

// ==== host_link_pkg.sv ====
`include "host_link_config.svh"

package host_link_pkg;

  typedef logic [`HL_WORD_W-1:0] mem_word_t;
  typedef logic [`HL_ADDR_W-1:0] mem_addr_t;

  // opcodes carried in the first byte of a host frame
  typedef enum logic [`HL_BYTE_W-1:0] {
    SET_DATA_LO = 8'h10,
    SET_DATA_HI = 8'h11,
    SET_ADDR_LO = 8'h12,
    SET_ADDR_HI = 8'h13,
    MEM_WRITE   = 8'hA0,
    MEM_READ    = 8'hA1,
    SCAN_START  = 8'hA3,
    SCAN_RESULT = 8'hA4
  } host_cmd_e;

  typedef enum logic [1:0] {
    LINK_IDLE,    // waiting for a start bit
    LINK_SHIFT,   // collecting command and data bits
    LINK_HOLD     // frame complete, waiting for cmd_done
  } link_state_e;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_EXEC,
    ENG_BUS,
    ENG_WAIT_SCAN
  } engine_state_e;

endpackage

// ==== mem_bus_if.sv ====
`include "host_link_config.svh"

interface mem_bus_if import host_link_pkg::*; ();

  logic      psel;
  logic      penable;
  logic      pwrite;
  mem_addr_t paddr;
  mem_word_t pwdata;
  mem_word_t prdata;
  logic      pready;

  modport requester (
    output psel,
    output penable,
    output pwrite,
    output paddr,
    output pwdata,
    input  prdata,
    input  pready
  );

  modport completer (
    input  psel,
    input  penable,
    input  pwrite,
    input  paddr,
    input  pwdata,
    output prdata,
    output pready
  );

endinterface

// ==== serial_host_port.sv ====
`include "host_link_config.svh"

module serial_host_port import host_link_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  sys_rst_n,
  input  logic                  host_clk,
  input  logic                  host_din,
  input  logic                  cmd_done,
  input  logic                  reply_valid,
  input  mem_word_t             reply_word,
  output logic                  cmd_valid,
  output host_cmd_e             cmd,
  output logic [`HL_BYTE_W-1:0] cmd_data,
  output logic                  host_dout
);

  localparam int FRAME_BITS = 2 * `HL_BYTE_W;
  localparam int REPLY_BITS = `HL_WORD_W + 2;   // start 1, word, stop 0
  localparam int TX_CNT_W   = $clog2(REPLY_BITS + 1);

  logic [`HL_SYNC_STAGES-1:0]    clk_sync;
  logic [`HL_SYNC_STAGES-1:0]    din_sync;
  logic                          clk_prev;
  logic                          clk_rise;
  logic                          din_s;
  link_state_e                   link_state;
  logic [$clog2(FRAME_BITS)-1:0] rx_cnt;
  logic [FRAME_BITS-1:0]         rx_shift;
  logic [TX_CNT_W-1:0]           tx_cnt;
  logic [REPLY_BITS-1:0]         tx_shift;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      clk_sync <= '0;
      din_sync <= '0;
      clk_prev <= 1'b0;
    end else begin
      clk_sync <= {clk_sync[`HL_SYNC_STAGES-2:0], host_clk};
      din_sync <= {din_sync[`HL_SYNC_STAGES-2:0], host_din};
      clk_prev <= clk_sync[`HL_SYNC_STAGES-1];
    end
  end

  assign clk_rise = clk_sync[`HL_SYNC_STAGES-1] & ~clk_prev;
  assign din_s    = din_sync[`HL_SYNC_STAGES-1];

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      link_state <= LINK_IDLE;
      rx_cnt     <= '0;
    end else begin
      case (link_state)
        LINK_IDLE: begin
          if (clk_rise && din_s) begin   // start bit
            link_state <= LINK_SHIFT;
            rx_cnt     <= '0;
          end
        end
        LINK_SHIFT: begin
          if (clk_rise) begin
            rx_cnt <= rx_cnt + 1'b1;
            if (rx_cnt == FRAME_BITS - 1) begin
              link_state <= LINK_HOLD;
            end
          end
        end
        LINK_HOLD: begin
          if (cmd_done) begin
            link_state <= LINK_IDLE;
          end
        end
        default: link_state <= LINK_IDLE;
      endcase
    end
  end

  // lsb first, so new bits enter at the top
  always_ff @(posedge sys_clk) begin
    if (link_state == LINK_SHIFT && clk_rise) begin
      rx_shift <= {din_s, rx_shift[FRAME_BITS-1:1]};
    end
  end

  assign cmd_valid = (link_state == LINK_HOLD);
  assign cmd       = host_cmd_e'(rx_shift[`HL_BYTE_W-1:0]);
  assign cmd_data  = rx_shift[FRAME_BITS-1:`HL_BYTE_W];

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      tx_cnt    <= '0;
      host_dout <= 1'b0;
    end else if (reply_valid) begin
      tx_cnt <= TX_CNT_W'(REPLY_BITS);
    end else if (clk_rise && tx_cnt != '0) begin
      host_dout <= tx_shift[0];
      tx_cnt    <= tx_cnt - 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reply_valid) begin
      tx_shift <= {1'b0, reply_word, 1'b1};
    end else if (clk_rise && tx_cnt != '0) begin
      tx_shift <= tx_shift >> 1;
    end
  end

endmodule

// ==== command_engine.sv ====
`include "host_link_config.svh"

module command_engine import host_link_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  sys_rst_n,
  input  logic                  cmd_valid,
  input  host_cmd_e             cmd,
  input  logic [`HL_BYTE_W-1:0] cmd_data,
  input  logic                  scan_busy,
  input  mem_word_t             scan_sum,
  output logic                  cmd_done,
  output logic                  reply_valid,
  output mem_word_t             reply_word,
  output logic                  scan_start,
  output mem_addr_t             scan_addr,
  mem_bus_if.requester          bus
);

  engine_state_e                    state;
  logic [`HL_BYTE_W-1:0]            data_lo;
  logic [`HL_BYTE_W-1:0]            data_hi;
  logic [`HL_BYTE_W-1:0]            addr_lo;
  logic [`HL_ADDR_W-`HL_BYTE_W-1:0] addr_hi;   // only the bits the memory needs

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state       <= ENG_IDLE;
      data_lo     <= '0;
      data_hi     <= '0;
      addr_lo     <= '0;
      addr_hi     <= '0;
      bus.psel    <= 1'b0;
      bus.penable <= 1'b0;
    end else begin
      case (state)
        ENG_IDLE: begin
          if (cmd_valid) begin
            state <= ENG_EXEC;
          end
        end
        ENG_EXEC: begin
          state <= ENG_IDLE;
          case (cmd)
            SET_DATA_LO: data_lo <= cmd_data;
            SET_DATA_HI: data_hi <= cmd_data;
            SET_ADDR_LO: addr_lo <= cmd_data;
            SET_ADDR_HI: addr_hi <= cmd_data[`HL_ADDR_W-`HL_BYTE_W-1:0];
            MEM_WRITE, MEM_READ: begin
              bus.psel <= 1'b1;   // setup cycle next
              state    <= ENG_BUS;
            end
            SCAN_RESULT: state <= ENG_WAIT_SCAN;
            default: state <= ENG_IDLE;   // scan start and unknown opcodes
          endcase
        end
        ENG_BUS: begin
          if (!bus.penable) begin
            bus.penable <= 1'b1;
          end else if (bus.pready) begin
            bus.psel    <= 1'b0;
            bus.penable <= 1'b0;
            state       <= ENG_IDLE;
          end
        end
        ENG_WAIT_SCAN: begin
          if (!scan_busy) begin
            state <= ENG_IDLE;
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  // request payload, held from setup through completion
  always_ff @(posedge sys_clk) begin
    if (state == ENG_EXEC) begin
      bus.pwrite <= (cmd == MEM_WRITE);
      bus.paddr  <= scan_addr;
      bus.pwdata <= {data_hi, data_lo};
    end
  end

  always_comb begin
    case (state)
      ENG_EXEC:      cmd_done = !(cmd inside {MEM_WRITE, MEM_READ, SCAN_RESULT});
      ENG_BUS:       cmd_done = bus.penable && bus.pready;
      ENG_WAIT_SCAN: cmd_done = !scan_busy;
      default:       cmd_done = 1'b0;
    endcase
  end

  assign reply_valid = cmd_done && (cmd == MEM_READ || cmd == SCAN_RESULT);
  assign reply_word  = (cmd == SCAN_RESULT) ? scan_sum : bus.prdata;
  assign scan_start  = (state == ENG_EXEC) && (cmd == SCAN_START) && !scan_busy;
  assign scan_addr   = {addr_hi, addr_lo};

endmodule

// ==== checksum_scanner.sv ====
`include "host_link_config.svh"

module checksum_scanner import host_link_pkg::*; (
  input  logic         sys_clk,
  input  logic         sys_rst_n,
  input  logic         scan_start,
  input  mem_addr_t    scan_addr,
  output logic         scan_busy,
  output mem_word_t    scan_sum,
  mem_bus_if.requester bus
);

  localparam int CNT_W = $clog2(`HL_SCAN_WORDS);

  logic [CNT_W-1:0] word_cnt;
  mem_word_t        acc;
  logic             xfer_done;

  assign xfer_done = bus.psel && bus.penable && bus.pready;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      scan_busy   <= 1'b0;
      scan_sum    <= '0;
      word_cnt    <= '0;
      acc         <= '0;
      bus.psel    <= 1'b0;
      bus.penable <= 1'b0;
    end else if (!scan_busy) begin
      if (scan_start) begin
        scan_busy <= 1'b1;
        word_cnt  <= '0;
        acc       <= '0;
        bus.psel  <= 1'b1;
      end
    end else if (xfer_done) begin
      acc         <= acc + bus.prdata;   // wraps mod 2^16
      word_cnt    <= word_cnt + 1'b1;
      bus.penable <= 1'b0;               // next setup follows directly
      if (word_cnt == CNT_W'(`HL_SCAN_WORDS - 1)) begin
        scan_busy <= 1'b0;
        scan_sum  <= acc + bus.prdata;
        bus.psel  <= 1'b0;
      end
    end else if (bus.psel && !bus.penable) begin
      bus.penable <= 1'b1;
    end
  end

  // address walks forward and wraps at the end of memory
  always_ff @(posedge sys_clk) begin
    if (!scan_busy && scan_start) begin
      bus.paddr <= scan_addr;
    end else if (xfer_done) begin
      bus.paddr <= (bus.paddr == mem_addr_t'(`HL_MEM_DEPTH - 1)) ? '0 : bus.paddr + 1'b1;
    end
  end

  assign bus.pwrite = 1'b0;   // read only
  assign bus.pwdata = '0;

endmodule

// ==== mem_arbiter.sv ====
module mem_arbiter (
  input  logic         sys_clk,
  input  logic         sys_rst_n,
  mem_bus_if.completer eng_bus,
  mem_bus_if.completer scan_bus,
  mem_bus_if.requester mem_bus
);

  logic busy_q;         // a transfer owns the memory bus
  logic owner_scan_q;
  logic gnt_eng;
  logic gnt_scan;
  logic done;

  always_comb begin
    if (busy_q) begin
      gnt_eng  = !owner_scan_q;
      gnt_scan = owner_scan_q;
    end else begin
      gnt_eng  = eng_bus.psel;   // engine wins ties
      gnt_scan = !eng_bus.psel && scan_bus.psel;
    end
  end

  assign done = mem_bus.psel && mem_bus.penable && mem_bus.pready;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      busy_q       <= 1'b0;
      owner_scan_q <= 1'b0;
    end else if (done) begin
      busy_q <= 1'b0;
    end else if (!busy_q && (gnt_eng || gnt_scan)) begin
      busy_q       <= 1'b1;
      owner_scan_q <= gnt_scan;
    end
  end

  // grant cycle is the setup cycle on the memory side
  assign mem_bus.psel    = gnt_scan ? scan_bus.psel : (gnt_eng && eng_bus.psel);
  assign mem_bus.penable = busy_q && (owner_scan_q ? scan_bus.penable : eng_bus.penable);
  assign mem_bus.pwrite  = gnt_scan ? scan_bus.pwrite : eng_bus.pwrite;
  assign mem_bus.paddr   = gnt_scan ? scan_bus.paddr : eng_bus.paddr;
  assign mem_bus.pwdata  = gnt_scan ? scan_bus.pwdata : eng_bus.pwdata;

  assign eng_bus.prdata  = mem_bus.prdata;
  assign scan_bus.prdata = mem_bus.prdata;
  assign eng_bus.pready  = gnt_eng && mem_bus.pready;
  assign scan_bus.pready = gnt_scan && mem_bus.pready;

endmodule

// ==== word_store.sv ====
`include "host_link_config.svh"

module word_store import host_link_pkg::*; (
  input  logic         sys_clk,
  input  logic         sys_rst_n,
  mem_bus_if.completer bus
);

  mem_word_t mem [`HL_MEM_DEPTH];
  logic      wait_q;   // first penable cycle seen

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wait_q <= 1'b0;
      for (int i = 0; i < `HL_MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (bus.psel && bus.penable) begin
      if (!wait_q) begin
        wait_q <= 1'b1;
      end else begin
        wait_q <= 1'b0;   // completion cycle
        if (bus.pwrite) begin
          mem[bus.paddr] <= bus.pwdata;
        end
      end
    end
  end

  assign bus.pready = bus.psel && bus.penable && wait_q;
  assign bus.prdata = mem[bus.paddr];

endmodule

// ==== host_bridge_top.sv ====
`include "host_link_config.svh"

module host_bridge_top import host_link_pkg::*; (
  input  logic sys_clk,
  input  logic sys_rst_n,
  input  logic host_clk,
  input  logic host_din,
  output logic host_dout,
  output logic busy
);

  logic                  cmd_valid;
  host_cmd_e             cmd;
  logic [`HL_BYTE_W-1:0] cmd_data;
  logic                  cmd_done;
  logic                  reply_valid;
  mem_word_t             reply_word;
  logic                  scan_start;
  mem_addr_t             scan_addr;
  logic                  scan_busy;
  mem_word_t             scan_sum;

  mem_bus_if eng_bus ();
  mem_bus_if scan_bus ();
  mem_bus_if mem_bus ();

  assign busy = cmd_valid;   // frame pending until the engine finishes

  serial_host_port serial_host_port_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .host_clk    (host_clk),
    .host_din    (host_din),
    .cmd_done    (cmd_done),
    .reply_valid (reply_valid),
    .reply_word  (reply_word),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_data    (cmd_data),
    .host_dout   (host_dout)
  );

  command_engine command_engine_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_data    (cmd_data),
    .scan_busy   (scan_busy),
    .scan_sum    (scan_sum),
    .cmd_done    (cmd_done),
    .reply_valid (reply_valid),
    .reply_word  (reply_word),
    .scan_start  (scan_start),
    .scan_addr   (scan_addr),
    .bus         (eng_bus.requester)
  );

  checksum_scanner checksum_scanner_i (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .scan_start (scan_start),
    .scan_addr  (scan_addr),
    .scan_busy  (scan_busy),
    .scan_sum   (scan_sum),
    .bus        (scan_bus.requester)
  );

  mem_arbiter mem_arbiter_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .eng_bus   (eng_bus.completer),
    .scan_bus  (scan_bus.completer),
    .mem_bus   (mem_bus.requester)
  );

  word_store word_store_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .bus       (mem_bus.completer)
  );

endmodule

// ==== host_bridge_props.sv ====
module host_bridge_props import host_link_pkg::*; (
  input logic      sys_clk,
  input logic      sys_rst_n,
  input logic      psel,
  input logic      penable,
  input logic      pready,
  input logic      pwrite,
  input mem_addr_t paddr,
  input mem_word_t pwdata,
  input logic      gnt_eng,
  input logic      gnt_scan
);

  // memory side request held from setup until the completing pready
  property req_stable;
    @(posedge sys_clk) disable iff (!sys_rst_n)
      (psel && !(penable && pready)) |=>
        (psel && $stable(pwrite) && $stable(paddr) && $stable(pwdata));
  endproperty

  property enable_needs_select;
    @(posedge sys_clk) disable iff (!sys_rst_n) penable |-> psel;
  endproperty

  // one owner per transfer, grant fixed from setup through completion
  property grant_held;
    @(posedge sys_clk) disable iff (!sys_rst_n)
      (psel && !(penable && pready)) |=> ($stable(gnt_eng) && $stable(gnt_scan));
  endproperty

  assert property (req_stable) else $error("memory request changed before pready");
  assert property (enable_needs_select) else $error("penable high without psel");
  assert property (grant_held) else $error("grant moved before the transfer completed");

endmodule

bind mem_arbiter host_bridge_props host_bridge_props_i (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .psel      (mem_bus.psel),
  .penable   (mem_bus.penable),
  .pready    (mem_bus.pready),
  .pwrite    (mem_bus.pwrite),
  .paddr     (mem_bus.paddr),
  .pwdata    (mem_bus.pwdata),
  .gnt_eng   (gnt_eng),
  .gnt_scan  (gnt_scan)
);

// ==== tb_host_bridge.sv ====
`include "host_link_config.svh"

module tb_host_bridge import host_link_pkg::*; ();

  localparam int N_WR   = 12;   // write then read back
  localparam int N_OVL  = 4;    // write followed directly by a second frame
  localparam int N_SCAN = 3;
  localparam int N_MIX  = 2;    // reads between scan start and result
  localparam int N_UNK  = 6;
  // reply collection counted like a frame
  localparam int N_FRAMES = 4 + N_WR * 9 + N_OVL * 10 + N_SCAN * 20 + N_MIX * 9
                            + N_UNK * 2 + 16;
  localparam longint WATCHDOG = longint'(N_FRAMES) * 40 * 8 * 4;
  localparam int AHI_W = `HL_ADDR_W - `HL_BYTE_W;

  logic sys_clk;
  logic sys_rst_n;
  logic host_clk;
  logic host_din;
  logic host_dout;
  logic busy;

  mem_word_t             model_mem [int];
  logic [`HL_BYTE_W-1:0] m_dlo;
  logic [`HL_BYTE_W-1:0] m_dhi;
  logic [`HL_BYTE_W-1:0] m_alo;
  logic [AHI_W-1:0]      m_ahi;
  mem_word_t             m_scan;   // sum of the last started scan
  mem_addr_t             written [$];
  int                    errors;
  int                    checks;
  int                    busy_rises = 0;
  logic                  busy_q = 1'b0;

  host_bridge_top host_bridge_top_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .host_clk  (host_clk),
    .host_din  (host_din),
    .host_dout (host_dout),
    .busy      (busy)
  );

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;
  end

  always @(negedge sys_clk) begin
    busy_q <= busy;
    if (busy && !busy_q) busy_rises <= busy_rises + 1;
  end

  initial begin
    #(WATCHDOG);
    $display("watchdog expired before the tests finished");
    $display("test failed");
    $finish;
  end

  function automatic mem_addr_t model_addr();
    return {m_ahi, m_alo};
  endfunction

  function automatic mem_word_t model_read(mem_addr_t a);
    if (model_mem.exists(int'(a))) return model_mem[int'(a)];
    return '0;   // memory clears on reset
  endfunction

  function automatic mem_word_t model_sum(mem_addr_t base);
    mem_word_t s;
    s = '0;
    for (int i = 0; i < `HL_SCAN_WORDS; i++) begin
      s += model_read(mem_addr_t'((int'(base) + i) % `HL_MEM_DEPTH));
    end
    return s;
  endfunction

  function automatic void model_update(logic [7:0] op, logic [7:0] data);
    case (op)
      SET_DATA_LO: m_dlo = data;
      SET_DATA_HI: m_dhi = data;
      SET_ADDR_LO: m_alo = data;
      SET_ADDR_HI: m_ahi = data[AHI_W-1:0];
      MEM_WRITE:   model_mem[int'(model_addr())] = {m_dhi, m_dlo};
      SCAN_START:  m_scan = model_sum(model_addr());
      default: ;
    endcase
  endfunction

  function automatic logic is_known(logic [7:0] op);
    return op inside {8'h10, 8'h11, 8'h12, 8'h13, 8'hA0, 8'hA1, 8'hA3, 8'hA4};
  endfunction

  function automatic mem_addr_t rand_addr();
    return mem_addr_t'($urandom_range(`HL_MEM_DEPTH - 1, 0));
  endfunction

  function automatic int scan_offset(mem_addr_t a, mem_addr_t base);
    return (int'(a) - int'(base) + `HL_MEM_DEPTH) % `HL_MEM_DEPTH;
  endfunction

  // a written address outside the scan window, if one turns up
  function automatic mem_addr_t pick_outside(mem_addr_t base);
    mem_addr_t a;
    mem_addr_t cand;
    a = mem_addr_t'((int'(base) + `HL_MEM_DEPTH / 2) % `HL_MEM_DEPTH);
    for (int k = 0; k < 20; k++) begin
      cand = written[$urandom_range(written.size() - 1, 0)];
      if (scan_offset(cand, base) >= `HL_SCAN_WORDS) a = cand;
    end
    return a;
  endfunction

  task automatic check_word(input string what, input mem_word_t got, input mem_word_t exp);
    checks++;
    if (got !== exp) begin
      $display("error at %0t: %s, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("error at %0t: %s, got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // one host_clk phase of 4 to 8 cycles, ends on a falling sys_clk edge
  task automatic toggle_half(input logic level, input logic din);
    int ph;
    ph = $urandom_range(8, 4);
    @(posedge sys_clk);
    host_clk <= level;
    host_din <= din;
    repeat (ph - 1) @(posedge sys_clk);
    @(negedge sys_clk);
  endtask

  task automatic send_frame(input logic [7:0] op, input logic [7:0] data);
    logic [2*`HL_BYTE_W:0] bits;
    bits = {data, op, 1'b1};   // start bit goes first
    for (int i = 0; i <= 2 * `HL_BYTE_W; i++) begin
      toggle_half(1'b0, bits[i]);
      toggle_half(1'b1, bits[i]);
    end
    toggle_half(1'b0, 1'b0);
  endtask

  task automatic issue(input logic [7:0] op, input logic [7:0] data);
    send_frame(op, data);
    model_update(op, data);
  endtask

  task automatic run_cmd(input logic [7:0] op, input logic [7:0] data);
    int base;
    int n;
    base = busy_rises;
    issue(op, data);
    n = 0;
    while ((busy_rises == base || busy) && n < 500) begin
      @(negedge sys_clk);
      n++;
    end
    checks++;
    if (n >= 500) begin
      $display("busy did not rise and fall after opcode %h", op);
      errors++;
    end
  endtask

  task automatic settle();
    int n;
    n = 0;
    while (busy && n < 500) begin
      @(negedge sys_clk);
      n++;
    end
    repeat (40) @(negedge sys_clk);
  endtask

  task automatic get_reply(output mem_word_t word);
    int   n;
    logic seen;
    word = '0;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < 40) begin   // host samples before each falling edge
      toggle_half(1'b1, 1'b0);
      seen = host_dout;
      toggle_half(1'b0, 1'b0);
      n++;
    end
    if (!seen) begin
      $display("no reply start bit came back on host_dout");
      errors++;
    end else begin
      for (int i = 0; i < `HL_WORD_W; i++) begin
        toggle_half(1'b1, 1'b0);
        word[i] = host_dout;
        toggle_half(1'b0, 1'b0);
      end
      toggle_half(1'b1, 1'b0);
      check_flag("reply stop bit", host_dout, 1'b0);
      toggle_half(1'b0, 1'b0);
      check_flag("busy at reply end", busy, 1'b0);
    end
  endtask

  task automatic expect_no_reply();
    int hits;
    hits = 0;
    repeat (20) begin
      toggle_half(1'b1, 1'b0);
      if (host_dout) hits++;
      toggle_half(1'b0, 1'b0);
    end
    check_flag("reply seen after unknown opcode", hits != 0, 1'b0);
  endtask

  task automatic set_addr(input mem_addr_t a);
    run_cmd(SET_ADDR_LO, a[`HL_BYTE_W-1:0]);
    run_cmd(SET_ADDR_HI, {{(2 * `HL_BYTE_W - `HL_ADDR_W){1'b0}}, a[`HL_ADDR_W-1:`HL_BYTE_W]});
  endtask

  task automatic set_staging(input mem_addr_t a, input mem_word_t d);
    set_addr(a);
    run_cmd(SET_DATA_LO, d[`HL_BYTE_W-1:0]);
    run_cmd(SET_DATA_HI, d[`HL_WORD_W-1:`HL_BYTE_W]);
  endtask

  task automatic write_word(input mem_addr_t a, input mem_word_t d);
    set_staging(a, d);
    run_cmd(MEM_WRITE, 8'h00);
  endtask

  task automatic read_check(input mem_addr_t a);
    mem_word_t w;
    set_addr(a);
    run_cmd(MEM_READ, 8'h00);
    get_reply(w);
    check_word($sformatf("read at %h", a), w, model_read(a));
  endtask

  task automatic scan_check(input string what);
    mem_word_t w;
    run_cmd(SCAN_RESULT, 8'h00);
    get_reply(w);
    check_word(what, w, m_scan);
  endtask

  task automatic report(input string name, input int mark);
    if (errors == mark) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - mark);
  endtask

  initial begin
    mem_addr_t  a;
    mem_addr_t  base;
    logic [7:0] op;
    int         mark;
    void'($urandom(61645));
    host_clk  = 1'b0;
    host_din  = 1'b0;
    sys_rst_n = 1'b0;
    errors    = 0;
    checks    = 0;
    m_dlo     = '0;
    m_dhi     = '0;
    m_alo     = '0;
    m_ahi     = '0;
    m_scan    = '0;
    repeat (5) @(posedge sys_clk);
    sys_rst_n <= 1'b1;
    @(negedge sys_clk);

    mark = errors;
    check_flag("busy after reset", busy, 1'b0);
    check_flag("host_dout after reset", host_dout, 1'b0);
    read_check(rand_addr());
    report("reset state and unwritten read", mark);

    mark = errors;
    repeat (N_WR) begin
      a = rand_addr();
      write_word(a, mem_word_t'($urandom));
      written.push_back(a);
    end
    foreach (written[i]) read_check(written[i]);
    report("random write and read back", mark);

    mark = errors;
    repeat (N_OVL) begin
      a = rand_addr();
      set_staging(a, mem_word_t'($urandom));
      issue(MEM_WRITE, 8'h00);
      issue(8'h00, 8'h00);   // second frame right behind the write
      settle();
      written.push_back(a);
      read_check(a);
    end
    report("busy and back to back frames", mark);

    mark = errors;
    for (int s = 0; s < N_SCAN; s++) begin
      if (s == 0) base = mem_addr_t'(`HL_MEM_DEPTH - 8 + $urandom_range(7, 0));   // wraps
      else base = rand_addr();
      repeat (3) begin
        a = mem_addr_t'((int'(base) + $urandom_range(`HL_SCAN_WORDS - 1, 0)) % `HL_MEM_DEPTH);
        write_word(a, mem_word_t'($urandom));
        written.push_back(a);
      end
      set_addr(base);
      run_cmd(SCAN_START, 8'h00);
      scan_check("scan sum");
    end
    report("block checksum", mark);

    mark = errors;
    repeat (N_MIX) begin
      base = rand_addr();
      set_addr(base);
      run_cmd(SCAN_START, 8'h00);
      read_check(pick_outside(base));
      scan_check("scan sum after read");
    end
    report("reads around a scan", mark);

    mark = errors;
    repeat (N_UNK) begin
      do op = 8'($urandom); while (is_known(op));
      run_cmd(op, 8'($urandom));
      expect_no_reply();
    end
    repeat (4) read_check(written[$urandom_range(written.size() - 1, 0)]);
    report("unknown opcodes", mark);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
host_link_pkg.sv
mem_bus_if.sv
serial_host_port.sv
command_engine.sv
checksum_scanner.sv
mem_arbiter.sv
word_store.sv
host_bridge_top.sv
host_bridge_props.sv
tb_host_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_host_bridge
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= test passed

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
